//--- design/emesh_pkg.sv
package emesh_pkg;

   //##############################
   // link field widths
   //##############################

   localparam int AW = 32;                 // address and data field width
   localparam int CW = 5;                  // ctrlmode field width
   localparam int PW = 1 + 2 + CW + 3 * AW;  // full packet, 104 bits

   //##############################
   // transfer size
   //##############################

   // datamode picks how many low bytes a write touches
   typedef enum logic [1:0] {
      DM_BYTE   = 2'b00,   // bits 7:0
      DM_HALF   = 2'b01,   // bits 15:0
      DM_WORD   = 2'b10,   // all 32 bits
      DM_DOUBLE = 2'b11    // 64 bits with high word in srcaddr
   } datamode_t;

   //##############################
   // packet layout
   //##############################

   // first member lands in the top bit
   typedef struct packed {
      logic          write;      // 1 for write, 0 for read request
      datamode_t     datamode;
      logic [CW-1:0] ctrlmode;   // passed back on read responses
      logic [AW-1:0] dstaddr;    // target address
      logic [AW-1:0] data;       // low data word
      logic [AW-1:0] srcaddr;    // return address or high data word
   } emesh_packet_t;

   // lane mask for the low data word of a write
   function automatic logic [AW-1:0] datamode_mask(datamode_t dm);
      logic [AW-1:0] mask;
      case (dm)
         DM_BYTE:
            mask = 32'h0000_00ff;
         DM_HALF:
            mask = 32'h0000_ffff;
         default:
            mask = '1;           // word and double take the whole word
      endcase
      return mask;
   endfunction

endpackage

//--- design/emesh_readback.sv
module emesh_readback (
   input  logic                     clk,
   input  logic                     nreset,
   input  logic                     access_in,   // request strobe
   input  logic                     ready_in,    // pushback from downstream
   input  emesh_pkg::emesh_packet_t packet_in,   // request packet
   input  logic [63:0]              read_data,   // registered in the bank
   output logic                     access_out,  // response strobe
   output emesh_pkg::emesh_packet_t packet_out,  // write-back packet
   output logic                     ready_out    // pushback to upstream
);

   // header fields kept from the read request
   typedef struct packed {
      emesh_pkg::datamode_t     datamode;
      logic [emesh_pkg::CW-1:0] ctrlmode;   // all 5 bits ride back
      logic [emesh_pkg::AW-1:0] dstaddr;    // from request srcaddr
   } rsp_hdr_t;

   logic     rd_take;   // accepted read
   rsp_hdr_t hdr_q;

   assign rd_take = access_in & ready_in & ~packet_in.write;

   //##############################
   // pipeline stage
   //##############################

   // holds while ready_in is low
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         access_out <= 1'b0;
      else if (ready_in)
         access_out <= access_in & ~packet_in.write;   // writes get no reply
   end

   always_ff @(posedge clk)
   begin
      if (rd_take)
      begin
         hdr_q.datamode <= packet_in.datamode;
         hdr_q.ctrlmode <= packet_in.ctrlmode;
         hdr_q.dstaddr  <= packet_in.srcaddr;   // send back to the requester
      end
   end

   // no buffering of our own
   assign ready_out = ready_in;

   //##############################
   // response packet
   //##############################

   assign packet_out = '{
      write:    1'b1,               // response is a write
      datamode: hdr_q.datamode,
      ctrlmode: hdr_q.ctrlmode,
      dstaddr:  hdr_q.dstaddr,
      data:     read_data[31:0],    // register at index
      srcaddr:  read_data[63:32]    // register at index+1
   };

   // read_data comes from the bank so this covers both blocks
   a_hold_on_stall : assert property (
      @(posedge clk) disable iff (!nreset)
      !ready_in |=> $stable(access_out) && (!access_out || $stable(packet_out))
   );

endmodule

//--- design/emesh_regbank.sv
module emesh_regbank #(
   parameter int          NUM_REGS = 8,            // power of two
   parameter logic [31:0] CHIP_ID  = 32'h0000_0000 // value of register 0
) (
   input  logic                     clk,
   input  logic                     nreset,
   input  logic                     access_in,   // one cycle strobe
   input  logic                     ready_in,    // downstream can take a response
   input  emesh_pkg::emesh_packet_t packet_in,
   output logic [63:0]              read_data    // {index+1, index}
);

   localparam int AW = emesh_pkg::AW;
   localparam int IW = $clog2(NUM_REGS);   // register index width

   logic [IW-1:0] idx;        // selected register
   logic [IW-1:0] idx_nxt;    // its neighbour for double accesses
   logic          wr_en;      // accepted write
   logic          rd_en;      // accepted read
   logic          wr_double;  // accepted double write
   logic [AW-1:0] wr_mask;    // datamode lanes
   logic [AW-1:0] regs [NUM_REGS];

   //##############################
   // decode
   //##############################

   assign idx     = packet_in.dstaddr[regbank_pkg::REG_BYTE_SHIFT +: IW];  // modulo NUM_REGS
   assign idx_nxt = idx + IW'(1);   // wraps back to 0

   // a packet counts only when downstream is ready
   assign wr_en = access_in & ready_in & packet_in.write;
   assign rd_en = access_in & ready_in & ~packet_in.write;

   assign wr_double = wr_en & (packet_in.datamode == emesh_pkg::DM_DOUBLE);
   assign wr_mask   = emesh_pkg::datamode_mask(packet_in.datamode);

   //##############################
   // storage
   //##############################

   for (genvar i = 0; i < NUM_REGS; i++)
   begin : g_reg
      if (i == int'(regbank_pkg::REG_ID))
      begin : g_id
         assign regs[i] = CHIP_ID;   // id is pinned, writes drop
      end
      else
      begin : g_rw
         logic sel_lo;   // low word lands here
         logic sel_hi;   // high word of a double lands here

         assign sel_lo = wr_en && (idx == IW'(i));
         assign sel_hi = wr_double && (idx_nxt == IW'(i));

         // sel_lo and sel_hi never hit the same register
         always_ff @(posedge clk or negedge nreset)
         begin
            if (!nreset)
               regs[i] <= regbank_pkg::REG_RESET;
            else if (sel_lo)
               regs[i] <= (regs[i] & ~wr_mask) | (packet_in.data & wr_mask);  // merge lanes
            else if (sel_hi)
               regs[i] <= packet_in.srcaddr;   // upper half of double
         end
      end
   end

   //##############################
   // read port
   //##############################

   // sampled at the accepting edge
   // a write one cycle earlier is already in regs
   always_ff @(posedge clk)
   begin
      if (rd_en)
         read_data <= {regs[idx_nxt], regs[idx]};
   end

   // readback builds its response from this one cycle later
   a_read_data_known : assert property (
      @(posedge clk) disable iff (!nreset)
      rd_en |=> !$isunknown(read_data)
   );

endmodule

//--- design/emesh_regs_top.sv
module emesh_regs_top #(
   parameter int          NUM_REGS = 8,              // power of two
   parameter logic [31:0] CHIP_ID  = 32'h0e5a_0001   // returned by register 0
) (
   input  logic                     clk,
   input  logic                     nreset,

   // request side
   input  logic                     access_in,
   input  emesh_pkg::emesh_packet_t packet_in,
   output logic                     ready_out,

   // response side
   output logic                     access_out,
   output emesh_pkg::emesh_packet_t packet_out,
   input  logic                     ready_in
);

   logic [63:0] read_data;   // bank to readback

   //##############################
   // register bank
   //##############################

   emesh_regbank #(
      .NUM_REGS (NUM_REGS),
      .CHIP_ID  (CHIP_ID)
   ) regbank_i (
      .clk       (clk),
      .nreset    (nreset),
      .access_in (access_in),
      .ready_in  (ready_in),
      .packet_in (packet_in),
      .read_data (read_data)
   );

   //##############################
   // response path
   //##############################

   // same request fans out to both blocks
   emesh_readback readback_i (
      .clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .ready_in   (ready_in),
      .packet_in  (packet_in),
      .read_data  (read_data),
      .access_out (access_out),
      .packet_out (packet_out),
      .ready_out  (ready_out)    // straight from ready_in
   );

endmodule

//--- design/regbank_pkg.sv
package regbank_pkg;

   //##############################
   // register map
   //##############################

   localparam int REG_INDEX_W    = 3;   // enough to name the default bank
   localparam int REG_BYTE_SHIFT = 2;   // one register per 4 byte stride

   // value every writable register comes out of reset with
   localparam logic [31:0] REG_RESET = 32'h0000_0000;

   // default 8 register layout
   typedef enum logic [REG_INDEX_W-1:0] {
      REG_ID       = 3'd0,   // read only, returns the chip id
      REG_CTRL     = 3'd1,   // control bits
      REG_STATUS   = 3'd2,   // status word
      REG_SCRATCH0 = 3'd3,
      REG_SCRATCH1 = 3'd4,
      REG_SCRATCH2 = 3'd5,
      REG_SCRATCH3 = 3'd6,
      REG_SCRATCH4 = 3'd7    // last index so a double write here wraps to id
   } reg_index_t;

   // note that ctrl and status have no side effects in this block
   // software treats them as plain storage

endpackage

//--- dv/tb_emesh_regs_top.sv
module tb_emesh_regs_top;

   timeunit 1ns;
   timeprecision 100ps;

   //##############################
   // run setup
   //##############################

   localparam int          NUM_REGS     = 8;
   localparam logic [31:0] CHIP_ID      = 32'h0e5a_0001;
   localparam int          CLK_PERIOD   = 8;
   localparam int          RESET_CYCLES = 10;
   localparam int          NUM_ENTRIES  = 24;
   localparam int          STALL_EVERY  = 4;   // forced stall on first try of every 4th entry
   localparam int          CYCLE_LIMIT  = 4 * NUM_ENTRIES + RESET_CYCLES + 32;
   localparam logic [31:0] LFSR_SEED    = 32'h5eb3d17a;
   localparam logic [31:0] ADDR_BASE    = 32'h4000_0100;   // bits above the index, ignored
   localparam int          ID_INDEX     = int'(regbank_pkg::REG_ID);

   // one row of the stimulus table
   typedef struct packed {
      logic                    write;
      emesh_pkg::datamode_t    datamode;
      regbank_pkg::reg_index_t index;
      logic [31:0]             data;
      logic [31:0]             srcaddr;    // return address, or high word of a double write
      logic [4:0]              ctrlmode;
   } entry_t;

   logic                     clk = 1'b0;
   logic                     nreset;
   logic                     access_in;
   emesh_pkg::emesh_packet_t packet_in;
   logic                     ready_out;
   logic                     access_out;
   emesh_pkg::emesh_packet_t packet_out;
   logic                     ready_in;

   logic [31:0] model [NUM_REGS];   // shadow of the bank
   logic [31:0] lfsr = LFSR_SEED;
   int          cycles = 0;
   int          access_errors = 0;
   int          packet_errors = 0;

   // write, datamode, register, data, srcaddr, ctrlmode
   entry_t stim [NUM_ENTRIES] = '{
      '{1'b0, emesh_pkg::DM_WORD,   regbank_pkg::REG_CTRL,     32'h0,          32'h1000_0040, 5'h03},
      '{1'b0, emesh_pkg::DM_WORD,   regbank_pkg::REG_ID,       32'h0,          32'h1000_0044, 5'h11},
      '{1'b1, emesh_pkg::DM_WORD,   regbank_pkg::REG_ID,       32'hdead_beef,  32'h0,         5'h00},
      '{1'b0, emesh_pkg::DM_WORD,   regbank_pkg::REG_ID,       32'h0,          32'h1000_0048, 5'h1f},
      '{1'b1, emesh_pkg::DM_WORD,   regbank_pkg::REG_CTRL,     32'h1234_5678,  32'h0,         5'h00},
      '{1'b1, emesh_pkg::DM_BYTE,   regbank_pkg::REG_CTRL,     32'hffff_ffaa,  32'h0,         5'h00},
      '{1'b0, emesh_pkg::DM_BYTE,   regbank_pkg::REG_CTRL,     32'h0,          32'h2000_0000, 5'h05},
      '{1'b1, emesh_pkg::DM_HALF,   regbank_pkg::REG_CTRL,     32'haaaa_bbcc,  32'h0,         5'h00},
      '{1'b0, emesh_pkg::DM_HALF,   regbank_pkg::REG_CTRL,     32'h0,          32'h2000_0004, 5'h0a},
      '{1'b1, emesh_pkg::DM_WORD,   regbank_pkg::REG_STATUS,   32'hcafe_f00d,  32'h0,         5'h00},
      '{1'b1, emesh_pkg::DM_BYTE,   regbank_pkg::REG_STATUS,   32'h0000_0011,  32'h0,         5'h00},
      '{1'b0, emesh_pkg::DM_WORD,   regbank_pkg::REG_STATUS,   32'h0,          32'h3000_0010, 5'h14},
      '{1'b1, emesh_pkg::DM_DOUBLE, regbank_pkg::REG_SCRATCH0, 32'h0bad_cafe,  32'h5555_aaaa, 5'h00},
      '{1'b0, emesh_pkg::DM_DOUBLE, regbank_pkg::REG_SCRATCH0, 32'h0,          32'h3000_0020, 5'h07},
      '{1'b1, emesh_pkg::DM_DOUBLE, regbank_pkg::REG_SCRATCH4, 32'h7777_8888,  32'h9999_0000, 5'h00},
      '{1'b0, emesh_pkg::DM_DOUBLE, regbank_pkg::REG_SCRATCH4, 32'h0,          32'h3000_0024, 5'h19},
      '{1'b1, emesh_pkg::DM_HALF,   regbank_pkg::REG_SCRATCH3, 32'h0000_4321,  32'h0,         5'h00},
      '{1'b0, emesh_pkg::DM_WORD,   regbank_pkg::REG_SCRATCH3, 32'h0,          32'h4000_0008, 5'h02},
      '{1'b1, emesh_pkg::DM_WORD,   regbank_pkg::REG_SCRATCH2, 32'h0f0f_0f0f,  32'h0,         5'h00},
      '{1'b0, emesh_pkg::DM_WORD,   regbank_pkg::REG_SCRATCH1, 32'h0,          32'h4000_000c, 5'h1c},
      '{1'b1, emesh_pkg::DM_BYTE,   regbank_pkg::REG_SCRATCH1, 32'h0000_00ee,  32'h0,         5'h00},
      '{1'b0, emesh_pkg::DM_DOUBLE, regbank_pkg::REG_SCRATCH1, 32'h0,          32'h5000_0000, 5'h09},
      '{1'b0, emesh_pkg::DM_DOUBLE, regbank_pkg::REG_ID,       32'h0,          32'h5000_0004, 5'h10},
      '{1'b0, emesh_pkg::DM_BYTE,   regbank_pkg::REG_STATUS,   32'h0,          32'h5000_0008, 5'h1f}
   };

   emesh_regs_top #(
      .NUM_REGS (NUM_REGS),
      .CHIP_ID  (CHIP_ID)
   ) emesh_regs_top_i (
      .clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .ready_out  (ready_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .ready_in   (ready_in)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // hard stop if the table never drains
   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT)
      begin
         $display("timeout after %0d cycles, the run did not finish", cycles);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   //##############################
   // back-pressure source
   //##############################

   // taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   task automatic take_bit(output logic b);
      lfsr = lfsr_next(lfsr);
      b    = lfsr[0];   // newest bit
   endtask

   task automatic draw_ready(output logic r);
      logic b0;
      logic b1;
      take_bit(b0);
      take_bit(b1);
      r = ~(b0 & b1);   // low about 1 in 4
   endtask

   //##############################
   // reference model
   //##############################

   function automatic logic [31:0] mask_for(input emesh_pkg::datamode_t dm);
      case (dm)
         emesh_pkg::DM_BYTE: return 32'h0000_00ff;
         emesh_pkg::DM_HALF: return 32'h0000_ffff;
         default:            return 32'hffff_ffff;
      endcase
   endfunction

   // register index from the byte address modulo bank size
   function automatic int reg_of(input emesh_pkg::emesh_packet_t p);
      return int'((p.dstaddr >> regbank_pkg::REG_BYTE_SHIFT) % NUM_REGS);
   endfunction

   function automatic logic [31:0] model_read(input int i);
      return (i == ID_INDEX) ? CHIP_ID : model[i];
   endfunction

   task automatic model_write(input emesh_pkg::emesh_packet_t p);
      int          idx;
      int          nxt;
      logic [31:0] m;
      idx = reg_of(p);
      nxt = (idx + 1) % NUM_REGS;   // pair partner wraps
      m   = mask_for(p.datamode);
      if (idx != ID_INDEX)
         model[idx] = (model[idx] & ~m) | (p.data & m);
      if (p.datamode == emesh_pkg::DM_DOUBLE && nxt != ID_INDEX)
         model[nxt] = p.srcaddr;   // high word
   endtask

   function automatic emesh_pkg::emesh_packet_t expected_response(
      input emesh_pkg::emesh_packet_t p
   );
      emesh_pkg::emesh_packet_t rsp;
      int                       idx;
      idx          = reg_of(p);
      rsp.write    = 1'b1;
      rsp.datamode = p.datamode;
      rsp.ctrlmode = p.ctrlmode;
      rsp.dstaddr  = p.srcaddr;   // back to the requester
      rsp.data     = model_read(idx);
      rsp.srcaddr  = model_read((idx + 1) % NUM_REGS);
      return rsp;
   endfunction

   function automatic emesh_pkg::emesh_packet_t build_request(input entry_t e);
      emesh_pkg::emesh_packet_t p;
      p.write    = e.write;
      p.datamode = e.datamode;
      p.ctrlmode = e.ctrlmode;
      p.dstaddr  = ADDR_BASE | (32'(e.index) << regbank_pkg::REG_BYTE_SHIFT);
      p.data     = e.data;
      p.srcaddr  = e.srcaddr;
      return p;
   endfunction

   // offered only on stalled edges, leaves a mark on both words if taken
   function automatic emesh_pkg::emesh_packet_t decoy_write(
      input emesh_pkg::emesh_packet_t p
   );
      emesh_pkg::emesh_packet_t d;
      d          = p;
      d.datamode = emesh_pkg::DM_DOUBLE;   // full word plus neighbour
      d.data     = ~p.data;
      d.srcaddr  = ~p.srcaddr;
      return d;
   endfunction

   //##############################
   // compare tasks
   //##############################

   task automatic check_access(input logic actual, input logic expected, input string what);
      if (actual !== expected)
      begin
         $display("FAIL %0t: %s got %b expected %b", $time, what, actual, expected);
         access_errors++;
      end
   endtask

   task automatic check_packet(input emesh_pkg::emesh_packet_t actual,
                               input emesh_pkg::emesh_packet_t expected,
                               input string what);
      if (actual !== expected)
      begin
         $display("FAIL %0t: %s got w=%b dm=%0d cm=%h dst=%h data=%h src=%h", $time, what,
                  actual.write, actual.datamode, actual.ctrlmode, actual.dstaddr,
                  actual.data, actual.srcaddr);
         $display("   expected w=%b dm=%0d cm=%h dst=%h data=%h src=%h",
                  expected.write, expected.datamode, expected.ctrlmode, expected.dstaddr,
                  expected.data, expected.srcaddr);
         packet_errors++;
      end
   endtask

   //##############################
   // stimulus
   //##############################

   // retries the row until an edge with ready high takes it
   task automatic apply_entry(input int n);
      emesh_pkg::emesh_packet_t req;
      emesh_pkg::emesh_packet_t held_packet;
      logic                     held_access;
      logic                     ready;
      logic                     accepted;
      int                       attempts;
      req      = build_request(stim[n]);
      accepted = 1'b0;
      attempts = 0;
      while (!accepted)
      begin
         held_access = access_out;   // settled since the last rising edge
         held_packet = packet_out;
         draw_ready(ready);
         if (attempts == 0 && (n % STALL_EVERY) == STALL_EVERY - 1)
            ready = 1'b0;
         access_in = 1'b1;
         packet_in = (ready || !req.write) ? req : decoy_write(req);
         ready_in  = ready;
         @(posedge clk);
         accepted = ready;
         attempts++;
         @(negedge clk);
         check_access(ready_out, ready, "ready_out vs ready_in");
         if (accepted)
         begin
            check_access(access_out, ~req.write, "access_out after accept");
            if (!req.write)
               check_packet(packet_out, expected_response(req), "read response");
            else
               model_write(req);   // visible to the next read
         end
         else
         begin
            // nothing moves on a stalled edge
            check_access(access_out, held_access, "access_out during stall");
            if (held_access)
               check_packet(packet_out, held_packet, "packet_out during stall");
         end
      end
   endtask

   initial
   begin
      nreset    = 1'b0;
      access_in = 1'b0;
      packet_in = '0;
      ready_in  = 1'b1;
      for (int i = 0; i < NUM_REGS; i++)
         model[i] = '0;

      repeat (RESET_CYCLES) @(negedge clk);
      check_access(access_out, 1'b0, "access_out in reset");
      nreset = 1'b1;
      @(negedge clk);
      check_access(access_out, 1'b0, "access_out after reset");

      for (int n = 0; n < NUM_ENTRIES; n++)
         apply_entry(n);

      // last response must drop once idle
      access_in = 1'b0;
      packet_in = '0;
      ready_in  = 1'b1;
      repeat (3)
      begin
         @(negedge clk);
         check_access(access_out, 1'b0, "access_out when idle");
      end

      $display("errors: access %0d, packet %0d, total %0d",
               access_errors, packet_errors, access_errors + packet_errors);
      if (access_errors + packet_errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

//--- emesh_regs_top.f
design/emesh_pkg.sv
design/regbank_pkg.sv
design/emesh_regbank.sv
design/emesh_readback.sv
design/emesh_regs_top.sv
dv/tb_emesh_regs_top.sv

//--- run.sh
#!/bin/sh
# compile and run the register block testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_emesh_regs_top
OBJ_DIR=obj_dir

if ! command -v verilator >/dev/null 2>&1
then
   echo "verilator not found on PATH"
   exit 1
fi

verilator --binary --timing --assert \
   -f emesh_regs_top.f \
   --top-module "$TOP" \
   -Mdir "$OBJ_DIR" \
   -o "$TOP"
status=$?
if [ "$status" -ne 0 ]
then
   echo "build failed with status $status"
   exit 1
fi

output=$("./$OBJ_DIR/$TOP")
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]
then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** TEST PASSED ***'
then
   exit 0
else
   exit 1
fi
